// File: nibble_if.sv
// fetch to decoder nibble link
`timescale 1ns/1ps
`default_nettype none

interface nibble_if;

  // fetched nibble offered to the decoder
  logic                    valid;
  saturn_isa_pkg::nibble_t nibble;
  saturn_isa_pkg::addr_t   addr;
  logic                    take;

  // program counter control
  logic                    load;
  saturn_isa_pkg::addr_t   load_addr;
  logic                    advance;
  saturn_isa_pkg::addr_t   cur_pc;

  modport fetch (output valid, nibble, addr, load, load_addr, advance, input take, cur_pc);

  // decoder also sees load so a restart drops a half decoded instruction
  modport dec (input valid, nibble, addr, load, output take);

  modport pc (input load, load_addr, advance, output cur_pc);

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the saturn front end testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_saturn_front \
  -f saturn_front.f -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log
test -s sim.log || { echo "build or run produced no log"; exit 1; }
grep -q "SIMULATION FAILED" sim.log && { echo "test failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without a result"; exit 1; }
echo "test passed"

// File: saturn_bus_pkg.sv
// nibble bus types
`default_nettype none

package saturn_bus_pkg;

  // wishbone address and data of the nibble memory
  typedef logic [19:0] wb_adr_t;
  typedef logic [3:0]  wb_dat_t;

  // fetch state machine
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_HOLD
  } fetch_state_t;

endpackage

`default_nettype wire

// File: saturn_decoder.sv
// nibble serial instruction decoder
`timescale 1ns/1ps
`default_nettype none

module saturn_decoder (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  saturn_isa_pkg::nibble_t   i_reg_p,
  nibble_if.dec                     nib,
  input  logic                      i_ins_ready,
  output logic                      o_ins_valid,
  output saturn_isa_pkg::ins_kind_t o_ins_kind,
  output saturn_isa_pkg::addr_t     o_ins_addr,
  output logic                      o_dec_error,
  output logic                      o_set_xm,
  output logic                      o_set_carry,
  output logic                      o_carry_val,
  output logic                      o_mode_dec,
  output logic                      o_direction,
  output saturn_isa_pkg::field_t    o_field,
  output saturn_isa_pkg::digit_t    o_field_start,
  output saturn_isa_pkg::digit_t    o_field_last,
  output saturn_isa_pkg::alu_op_t   o_alu_op
);

  saturn_isa_pkg::dec_state_t state;
  logic                       accept;
  logic                       field_ok;

  // f table, returns field code, start digit and last digit
  function automatic logic [11:0] f_table(saturn_isa_pkg::nibble_t n,
                                          saturn_isa_pkg::nibble_t p);
    case (n)
      4'h0:    f_table = {saturn_isa_pkg::FIELD_P, p, p};
      4'h1:    f_table = {saturn_isa_pkg::FIELD_WP, 4'd0, p};
      4'h2:    f_table = {saturn_isa_pkg::FIELD_XS, 4'd2, 4'd2};
      4'h3:    f_table = {saturn_isa_pkg::FIELD_X, 4'd0, 4'd2};
      4'h4:    f_table = {saturn_isa_pkg::FIELD_S, 4'd15, 4'd15};
      4'h5:    f_table = {saturn_isa_pkg::FIELD_M, 4'd3, 4'd14};
      4'h6:    f_table = {saturn_isa_pkg::FIELD_B, 4'd0, 4'd1};
      4'h7:    f_table = {saturn_isa_pkg::FIELD_W, 4'd0, 4'd15};
      4'hF:    f_table = {saturn_isa_pkg::FIELD_A, 4'd0, 4'd4};
      default: f_table = {saturn_isa_pkg::FIELD_NONE, 4'd0, 4'd0};
    endcase
  endfunction

  // no new nibble while a result waits
  assign nib.take    = (state != saturn_isa_pkg::DEC_DONE);
  assign accept      = nib.valid && nib.take;
  assign o_ins_valid = (state == saturn_isa_pkg::DEC_DONE);

  // 8 to E have no field in the f table
  assign field_ok = !nib.nibble[3] || (nib.nibble == 4'hF);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= saturn_isa_pkg::DEC_FIRST;
    end else if (state == saturn_isa_pkg::DEC_DONE) begin
      if (i_ins_ready) begin
        state <= saturn_isa_pkg::DEC_FIRST;
      end
    end else if (nib.load) begin
      state <= saturn_isa_pkg::DEC_FIRST;
    end else if (accept) begin
      case (state)
        saturn_isa_pkg::DEC_FIRST: begin
          state <= (nib.nibble == 4'h0) ? saturn_isa_pkg::DEC_BLOCK_0X
                                        : saturn_isa_pkg::DEC_DONE;
        end
        saturn_isa_pkg::DEC_BLOCK_0X: begin
          state <= (nib.nibble == 4'hE) ? saturn_isa_pkg::DEC_FIELD_F
                                        : saturn_isa_pkg::DEC_DONE;
        end
        saturn_isa_pkg::DEC_FIELD_F: begin
          state <= field_ok ? saturn_isa_pkg::DEC_OP_0E : saturn_isa_pkg::DEC_DONE;
        end
        default: begin
          state <= saturn_isa_pkg::DEC_DONE;
        end
      endcase
    end
  end

  // decoded instruction, built up nibble by nibble
  always_ff @(posedge i_clk) begin
    if (accept) begin
      case (state)
        saturn_isa_pkg::DEC_FIRST: begin
          o_ins_kind    <= saturn_isa_pkg::INS_NONE;
          o_ins_addr    <= nib.addr;
          o_dec_error   <= (nib.nibble != 4'h0);
          o_set_xm      <= 1'b0;
          o_set_carry   <= 1'b0;
          o_carry_val   <= 1'b0;
          o_mode_dec    <= 1'b0;
          o_direction   <= 1'b0;
          o_field       <= saturn_isa_pkg::FIELD_NONE;
          o_field_start <= '0;
          o_field_last  <= '0;
          o_alu_op      <= saturn_isa_pkg::ALU_OP_NONE;
        end
        saturn_isa_pkg::DEC_BLOCK_0X: begin
          case (nib.nibble)
            4'h0, 4'h1, 4'h2, 4'h3: begin
              o_ins_kind  <= saturn_isa_pkg::INS_RTN;
              o_set_xm    <= (nib.nibble == 4'h0);
              o_set_carry <= (nib.nibble[3:1] == 3'b001);
              // RTNSC sets carry, RTNCC clears it
              o_carry_val <= (nib.nibble == 4'h2);
            end
            4'h4, 4'h5: begin
              o_ins_kind <= saturn_isa_pkg::INS_SET_MODE;
              o_mode_dec <= nib.nibble[0];
            end
            4'h6, 4'h7: begin
              o_ins_kind  <= saturn_isa_pkg::INS_RSTK_C;
              o_direction <= nib.nibble[0];
            end
            4'hE: begin
              o_dec_error <= 1'b0;
            end
            default: begin
              o_dec_error <= 1'b1;
            end
          endcase
        end
        saturn_isa_pkg::DEC_FIELD_F: begin
          // p taken as it stands when the field nibble arrives
          {o_field, o_field_start, o_field_last} <= f_table(nib.nibble, i_reg_p);
          o_dec_error <= !field_ok;
        end
        default: begin
          o_ins_kind <= saturn_isa_pkg::INS_ALU_OP;
          o_alu_op   <= nib.nibble[3] ? saturn_isa_pkg::ALU_OP_OR : saturn_isa_pkg::ALU_OP_AND;
        end
      endcase
    end
  end

  // held result does not change under back-pressure
  assert property (@(posedge i_clk) disable iff (i_reset)
    o_ins_valid && !i_ins_ready |=> o_ins_valid &&
      $stable({o_ins_kind, o_ins_addr, o_dec_error, o_set_xm, o_set_carry, o_carry_val,
               o_mode_dec, o_direction, o_field, o_field_start, o_field_last, o_alu_op}));

endmodule

`default_nettype wire

// File: saturn_fetch_fsm.sv
// wishbone nibble fetch
`timescale 1ns/1ps
`default_nettype none

module saturn_fetch_fsm (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_start,
  input  saturn_isa_pkg::addr_t   i_start_addr,
  output logic                    o_wb_cyc,
  output logic                    o_wb_stb,
  output logic                    o_wb_we,
  output saturn_bus_pkg::wb_adr_t o_wb_adr,
  input  saturn_bus_pkg::wb_dat_t i_wb_dat,
  input  logic                    i_wb_ack,
  nibble_if.fetch                 nib
);

  saturn_bus_pkg::fetch_state_t state;
  saturn_isa_pkg::nibble_t      nib_q;
  saturn_isa_pkg::addr_t        addr_q;
  logic                         bus_done;

  // classic read cycle, one nibble per ack
  assign o_wb_cyc = (state == saturn_bus_pkg::FETCH_REQ);
  assign o_wb_stb = (state == saturn_bus_pkg::FETCH_REQ);
  assign o_wb_we  = 1'b0;
  assign o_wb_adr = nib.cur_pc;

  assign bus_done = o_wb_stb && i_wb_ack;

  // pc control
  assign nib.load      = i_start;
  assign nib.load_addr = i_start_addr;
  assign nib.advance   = bus_done && !i_start;

  // a restart throws the held nibble away
  assign nib.valid  = (state == saturn_bus_pkg::FETCH_HOLD) && !i_start;
  assign nib.nibble = nib_q;
  assign nib.addr   = addr_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= saturn_bus_pkg::FETCH_IDLE;
    end else if (i_start) begin
      state <= saturn_bus_pkg::FETCH_REQ;
    end else begin
      case (state)
        saturn_bus_pkg::FETCH_REQ: begin
          if (i_wb_ack) begin
            state <= saturn_bus_pkg::FETCH_HOLD;
          end
        end
        saturn_bus_pkg::FETCH_HOLD: begin
          // next read starts once the decoder has the nibble
          if (nib.valid && nib.take) begin
            state <= saturn_bus_pkg::FETCH_REQ;
          end
        end
        default: begin
          state <= saturn_bus_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

  // nibble and its address
  always_ff @(posedge i_clk) begin
    if (bus_done) begin
      nib_q  <= i_wb_dat;
      addr_q <= nib.cur_pc;
    end
  end

  assert property (@(posedge i_clk) disable iff (i_reset)
    o_wb_stb |-> o_wb_cyc);

  // pc only moves on ack or restart
  assert property (@(posedge i_clk) disable iff (i_reset)
    o_wb_stb && !i_wb_ack && !i_start |=> $stable(o_wb_adr));

endmodule

`default_nettype wire

// File: saturn_front.f
saturn_isa_pkg.sv
saturn_bus_pkg.sv
nibble_if.sv
saturn_pc.sv
saturn_fetch_fsm.sv
saturn_decoder.sv
saturn_front_top.sv
tb_clk_gen.sv
tb_saturn_front.sv

// File: saturn_front_top.sv
// saturn instruction front end
`timescale 1ns/1ps
`default_nettype none

module saturn_front_top (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_start,
  input  saturn_isa_pkg::addr_t     i_start_addr,
  input  saturn_isa_pkg::nibble_t   i_reg_p,
  output logic                      o_wb_cyc,
  output logic                      o_wb_stb,
  output logic                      o_wb_we,
  output saturn_bus_pkg::wb_adr_t   o_wb_adr,
  input  saturn_bus_pkg::wb_dat_t   i_wb_dat,
  input  logic                      i_wb_ack,
  input  logic                      i_ins_ready,
  output logic                      o_ins_valid,
  output saturn_isa_pkg::ins_kind_t o_ins_kind,
  output saturn_isa_pkg::addr_t     o_ins_addr,
  output logic                      o_dec_error,
  output logic                      o_set_xm,
  output logic                      o_set_carry,
  output logic                      o_carry_val,
  output logic                      o_mode_dec,
  output logic                      o_direction,
  output saturn_isa_pkg::field_t    o_field,
  output saturn_isa_pkg::digit_t    o_field_start,
  output saturn_isa_pkg::digit_t    o_field_last,
  output saturn_isa_pkg::alu_op_t   o_alu_op
);

  nibble_if nib_bus ();

  saturn_pc u_pc (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .pc_if   (nib_bus.pc)
  );

  saturn_fetch_fsm u_fetch (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_start      (i_start),
    .i_start_addr (i_start_addr),
    .o_wb_cyc     (o_wb_cyc),
    .o_wb_stb     (o_wb_stb),
    .o_wb_we      (o_wb_we),
    .o_wb_adr     (o_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .i_wb_ack     (i_wb_ack),
    .nib          (nib_bus.fetch)
  );

  saturn_decoder u_dec (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_reg_p       (i_reg_p),
    .nib           (nib_bus.dec),
    .i_ins_ready   (i_ins_ready),
    .o_ins_valid   (o_ins_valid),
    .o_ins_kind    (o_ins_kind),
    .o_ins_addr    (o_ins_addr),
    .o_dec_error   (o_dec_error),
    .o_set_xm      (o_set_xm),
    .o_set_carry   (o_set_carry),
    .o_carry_val   (o_carry_val),
    .o_mode_dec    (o_mode_dec),
    .o_direction   (o_direction),
    .o_field       (o_field),
    .o_field_start (o_field_start),
    .o_field_last  (o_field_last),
    .o_alu_op      (o_alu_op)
  );

endmodule

`default_nettype wire

// File: saturn_isa_pkg.sv
// saturn instruction set types
`default_nettype none

package saturn_isa_pkg;

  // one instruction nibble and a nibble address
  typedef logic [3:0]  nibble_t;
  typedef logic [19:0] addr_t;

  // field code and digit index of a register field
  typedef logic [3:0] field_t;
  typedef logic [3:0] digit_t;

  // field codes, the first eight match the f table nibble
  localparam field_t FIELD_P    = 4'h0;
  localparam field_t FIELD_WP   = 4'h1;
  localparam field_t FIELD_XS   = 4'h2;
  localparam field_t FIELD_X    = 4'h3;
  localparam field_t FIELD_S    = 4'h4;
  localparam field_t FIELD_M    = 4'h5;
  localparam field_t FIELD_B    = 4'h6;
  localparam field_t FIELD_W    = 4'h7;
  localparam field_t FIELD_A    = 4'hA;
  localparam field_t FIELD_NONE = 4'hF;

  // alu operation codes
  typedef logic [4:0] alu_op_t;

  localparam alu_op_t ALU_OP_NONE = 5'd0;
  localparam alu_op_t ALU_OP_AND  = 5'd8;
  localparam alu_op_t ALU_OP_OR   = 5'd9;

  // class of a decoded instruction
  typedef enum logic [2:0] {
    INS_NONE,
    INS_RTN,
    INS_SET_MODE,
    INS_RSTK_C,
    INS_ALU_OP
  } ins_kind_t;

  // decoder position inside an instruction
  typedef enum logic [2:0] {
    DEC_FIRST,
    DEC_BLOCK_0X,
    DEC_FIELD_F,
    DEC_OP_0E,
    DEC_DONE
  } dec_state_t;

endpackage

`default_nettype wire

// File: saturn_pc.sv
// fetch program counter
`timescale 1ns/1ps
`default_nettype none

module saturn_pc (
  input  logic i_clk,
  input  logic i_reset,
  nibble_if.pc pc_if
);

  // load wins over advance, wraps at the top of the 1M nibble space
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_if.cur_pc <= '0;
    end else if (pc_if.load) begin
      pc_if.cur_pc <= pc_if.load_addr;
    end else if (pc_if.advance) begin
      pc_if.cur_pc <= pc_if.cur_pc + saturn_isa_pkg::addr_t'(1);
    end
  end

  // fetch drops the bus ack of an aborted read
  assert property (@(posedge i_clk) disable iff (i_reset)
    !(pc_if.load && pc_if.advance));

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // released just after an edge, like every other input
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2;
    o_reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_saturn_front.sv
// saturn front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_front;

  localparam int MEM_SIZE       = 4096;
  localparam int NUM_INS        = 400;
  localparam int RESTART_AT     = 250;
  localparam int IDLE_CYCLES    = 8;
  localparam int DRIVE_DELAY    = 2;
  // four nibbles of up to four bus cycles plus hold, and ready stalls
  localparam int CYCLES_PER_INS = 40;
  localparam int TIMEOUT_CYCLES = NUM_INS * CYCLES_PER_INS + 64;
  localparam logic [31:0] SEED  = 32'h6a2ddf55;
  localparam saturn_isa_pkg::addr_t FIRST_ADDR  = 20'h3A010;
  localparam saturn_isa_pkg::addr_t SECOND_ADDR = 20'h5C7F3;

  typedef struct packed {
    saturn_isa_pkg::ins_kind_t kind;
    logic                      err;
    logic                      set_xm;
    logic                      set_carry;
    logic                      carry_val;
    logic                      mode_dec;
    logic                      direction;
    saturn_isa_pkg::field_t    field;
    saturn_isa_pkg::digit_t    start;
    saturn_isa_pkg::digit_t    last;
    saturn_isa_pkg::alu_op_t   alu;
    logic [2:0]                len;
  } expect_t;

  logic                      clk;
  logic                      reset;
  logic                      i_start;
  saturn_isa_pkg::addr_t     i_start_addr;
  saturn_isa_pkg::nibble_t   i_reg_p;
  logic                      o_wb_cyc;
  logic                      o_wb_stb;
  logic                      o_wb_we;
  saturn_bus_pkg::wb_adr_t   o_wb_adr;
  saturn_bus_pkg::wb_dat_t   i_wb_dat;
  logic                      i_wb_ack;
  logic                      i_ins_ready;
  logic                      o_ins_valid;
  saturn_isa_pkg::ins_kind_t o_ins_kind;
  saturn_isa_pkg::addr_t     o_ins_addr;
  logic                      o_dec_error;
  logic                      o_set_xm;
  logic                      o_set_carry;
  logic                      o_carry_val;
  logic                      o_mode_dec;
  logic                      o_direction;
  saturn_isa_pkg::field_t    o_field;
  saturn_isa_pkg::digit_t    o_field_start;
  saturn_isa_pkg::digit_t    o_field_last;
  saturn_isa_pkg::alu_op_t   o_alu_op;

  saturn_isa_pkg::nibble_t mem [0:MEM_SIZE-1];
  logic [31:0]             lfsr_state;
  logic [1:0]              wait_left;
  logic                    restarted;
  int                      p_seen_count;
  saturn_isa_pkg::addr_t   exp_addr = '0;
  expect_t                 cur_exp;
  int                      ins_count = 0;
  int                      err_count = 0;
  int                      alu_count = 0;
  int                      cycle_count = 0;

  tb_clk_gen u_clk (
    .o_clk   (clk),
    .o_reset (reset)
  );

  saturn_front_top UUT (
    .i_clk         (clk),
    .i_reset       (reset),
    .i_start       (i_start),
    .i_start_addr  (i_start_addr),
    .i_reg_p       (i_reg_p),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .o_wb_we       (o_wb_we),
    .o_wb_adr      (o_wb_adr),
    .i_wb_dat      (i_wb_dat),
    .i_wb_ack      (i_wb_ack),
    .i_ins_ready   (i_ins_ready),
    .o_ins_valid   (o_ins_valid),
    .o_ins_kind    (o_ins_kind),
    .o_ins_addr    (o_ins_addr),
    .o_dec_error   (o_dec_error),
    .o_set_xm      (o_set_xm),
    .o_set_carry   (o_set_carry),
    .o_carry_val   (o_carry_val),
    .o_mode_dec    (o_mode_dec),
    .o_direction   (o_direction),
    .o_field       (o_field),
    .o_field_start (o_field_start),
    .o_field_last  (o_field_last),
    .o_alu_op      (o_alu_op)
  );

  // right shift galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // whole instructions, about one in ten broken at some nibble
  task automatic fill_memory();
    int                      a;
    int                      len;
    logic [4:0]              pick;
    saturn_isa_pkg::nibble_t ins [4];
    a = 0;
    while (a < MEM_SIZE) begin
      pick   = 5'(rand_bits(5));
      ins[0] = 4'h0;
      ins[1] = 4'hE;
      ins[2] = {1'b0, 3'(rand_bits(3))};
      ins[3] = 4'(rand_bits(4));
      len    = 4;
      if (pick < 5'd14) begin
        ins[1] = {1'b0, 3'(rand_bits(3))};
        len    = 2;
      end else if (pick < 5'd29) begin
        if (ins[2] == 4'h7 && rand_bits(1) != 32'd0) begin
          ins[2] = 4'hF;
        end
      end else if (pick == 5'd29) begin
        ins[0] = {1'b1, 3'(rand_bits(3))};
        len    = 1;
      end else if (pick == 5'd30) begin
        ins[1] = (rand_bits(1) != 32'd0) ? 4'hF : {1'b1, 3'(rand_bits(2))};
        len    = 2;
      end else begin
        ins[2] = {1'b1, 3'(rand_bits(3))};
        ins[2] = (ins[2] == 4'hF) ? 4'h8 : ins[2];
        len    = 3;
      end
      for (int k = 0; k < len && a < MEM_SIZE; k++) begin
        mem[12'(a)] = ins[k];
        a++;
      end
    end
  endtask

  function automatic saturn_isa_pkg::nibble_t mem_at(input saturn_isa_pkg::addr_t a,
                                                     input int k);
    saturn_isa_pkg::addr_t x;
    x = a + saturn_isa_pkg::addr_t'(k);
    return mem[x[11:0]];
  endfunction

  // expected decode of the instruction at a, with p the current P register
  function automatic expect_t ref_decode(input saturn_isa_pkg::addr_t a,
                                         input saturn_isa_pkg::nibble_t p);
    expect_t                 e;
    saturn_isa_pkg::nibble_t n1;
    saturn_isa_pkg::nibble_t n2;
    saturn_isa_pkg::nibble_t n3;
    e       = '0;
    e.field = saturn_isa_pkg::FIELD_NONE;
    e.alu   = saturn_isa_pkg::ALU_OP_NONE;
    e.len   = 3'd1;
    n1      = mem_at(a, 1);
    n2      = mem_at(a, 2);
    n3      = mem_at(a, 3);
    if (mem_at(a, 0) != 4'h0) begin
      e.err = 1'b1;
    end else begin
      e.len = 3'd2;
      case (n1)
        4'h0, 4'h1, 4'h2, 4'h3: begin
          // RTNSXM, RTN, RTNSC, RTNCC
          e.kind      = saturn_isa_pkg::INS_RTN;
          e.set_xm    = (n1 == 4'h0);
          e.set_carry = (n1 == 4'h2) || (n1 == 4'h3);
          e.carry_val = (n1 == 4'h2);
        end
        4'h4, 4'h5: begin
          e.kind     = saturn_isa_pkg::INS_SET_MODE;
          e.mode_dec = (n1 == 4'h5);
        end
        4'h6, 4'h7: begin
          e.kind      = saturn_isa_pkg::INS_RSTK_C;
          e.direction = (n1 == 4'h7);
        end
        4'hE: begin
          e.len = 3'd3;
          case (n2)
            4'h0:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_P, p, p};
            4'h1:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_WP, 4'd0, p};
            4'h2:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_XS, 4'd2, 4'd2};
            4'h3:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_X, 4'd0, 4'd2};
            4'h4:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_S, 4'd15, 4'd15};
            4'h5:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_M, 4'd3, 4'd14};
            4'h6:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_B, 4'd0, 4'd1};
            4'h7:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_W, 4'd0, 4'd15};
            4'hF:    {e.field, e.start, e.last} = {saturn_isa_pkg::FIELD_A, 4'd0, 4'd4};
            default: e.err = 1'b1;
          endcase
          if (!e.err) begin
            e.len  = 3'd4;
            e.kind = saturn_isa_pkg::INS_ALU_OP;
            e.alu  = n3[3] ? saturn_isa_pkg::ALU_OP_OR : saturn_isa_pkg::ALU_OP_AND;
          end
        end
        default: begin
          e.err = 1'b1;
        end
      endcase
    end
    return e;
  endfunction

  // wishbone slave, ready and P register, once per cycle after the edge
  task automatic drive_cycle();
    check_value("o_wb_we", 32'(o_wb_we), 32'd0);
    // cyc and stb rise and fall together
    check_value("o_wb_stb", 32'(o_wb_stb), 32'(o_wb_cyc));
    if (i_wb_ack) begin
      i_wb_ack  = 1'b0;
      wait_left = 2'(rand_bits(2));
    end else if (o_wb_cyc && o_wb_stb) begin
      if (wait_left == 2'd0) begin
        i_wb_ack = 1'b1;
        i_wb_dat = mem[o_wb_adr[11:0]];
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
    i_ins_ready = (rand_bits(2) != 32'd0);
    // new P only right after a handshake, so it holds through the next decode
    if (ins_count != p_seen_count) begin
      p_seen_count = ins_count;
      i_reg_p      = 4'(rand_bits(4));
    end
  endtask

  // compare at mid cycle while outputs and inputs are settled
  always @(negedge clk) begin
    if (i_start) begin
      exp_addr = i_start_addr;
    end else if (o_ins_valid) begin
      cur_exp = ref_decode(exp_addr, i_reg_p);
      check_value("o_ins_addr", 32'(o_ins_addr), 32'(exp_addr));
      check_value("o_ins_kind", 32'(o_ins_kind), 32'(cur_exp.kind));
      check_value("o_dec_error", 32'(o_dec_error), 32'(cur_exp.err));
      check_value("o_set_xm", 32'(o_set_xm), 32'(cur_exp.set_xm));
      check_value("o_set_carry", 32'(o_set_carry), 32'(cur_exp.set_carry));
      check_value("o_carry_val", 32'(o_carry_val), 32'(cur_exp.carry_val));
      check_value("o_mode_dec", 32'(o_mode_dec), 32'(cur_exp.mode_dec));
      check_value("o_direction", 32'(o_direction), 32'(cur_exp.direction));
      check_value("o_field", 32'(o_field), 32'(cur_exp.field));
      check_value("o_field_start", 32'(o_field_start), 32'(cur_exp.start));
      check_value("o_field_last", 32'(o_field_last), 32'(cur_exp.last));
      check_value("o_alu_op", 32'(o_alu_op), 32'(cur_exp.alu));
      if (i_ins_ready) begin
        exp_addr  = exp_addr + saturn_isa_pkg::addr_t'(cur_exp.len);
        ins_count = ins_count + 1;
        err_count = err_count + (cur_exp.err ? 1 : 0);
        alu_count = alu_count + ((cur_exp.kind == saturn_isa_pkg::INS_ALU_OP) ? 1 : 0);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d instructions decoded", cycle_count, ins_count);
      $display("SIMULATION FAILED");
      $fatal(1, "run did not complete");
    end
  end

  initial begin
    i_start      = 1'b0;
    i_start_addr = '0;
    i_reg_p      = '0;
    i_wb_dat     = '0;
    i_wb_ack     = 1'b0;
    i_ins_ready  = 1'b0;
    wait_left    = 2'd0;
    restarted    = 1'b0;
    p_seen_count = 0;
    lfsr_state   = SEED;
    fill_memory();
    i_reg_p = 4'(rand_bits(4));
    @(negedge reset);
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      check_value("o_wb_cyc", 32'(o_wb_cyc), 32'd0);
      check_value("o_wb_stb", 32'(o_wb_stb), 32'd0);
      check_value("o_ins_valid", 32'(o_ins_valid), 32'd0);
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    i_start      = 1'b1;
    i_start_addr = FIRST_ADDR;
    while (ins_count < NUM_INS) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      i_start = 1'b0;
      drive_cycle();
      // restart only while no result is on offer
      if (!restarted && ins_count >= RESTART_AT && !o_ins_valid) begin
        i_start      = 1'b1;
        i_start_addr = SECOND_ADDR;
        restarted    = 1'b1;
      end
    end
    if (err_count == 0 || alu_count == 0) begin
      $display("stimulus did not reach both decode errors and alu instructions");
      $display("SIMULATION FAILED");
      $fatal(1, "incomplete stimulus");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
